/* project.f */
+incdir+src
src/rvPkg.sv
src/decoder.sv
src/immGen.sv
src/alu.sv
src/regFile.sv
src/dataMem.sv
src/coreTop.sv
sim/tbCore.sv

/* sim/tbCore.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tbCore;

    localparam logic [31:0] EBREAK = 32'h0010_0073;
    localparam logic [31:0] FILLER = 32'h001f_8f93;  // addi x31, x31, 1

    logic              clk = 1'b0;
    logic              rstN;
    logic [31:0]       inst;
    logic [`XLEN-1:0]  pc;
    logic              rdWe;
    logic [4:0]        rdAddr;
    logic [`XLEN-1:0]  rdData;
    logic              halt;

    logic [31:0]  prog [`IMEM_WORDS];
    int           progLen;
    int unsigned  lcgState = 32'd57206;
    int           checks = 0;
    int           errors = 0;
    int           haltCycles = 0;

    // reference model state
    logic [63:0]  mReg [32];
    logic [7:0]   mMem [`DMEM_BYTES];
    logic [63:0]  mPc;
    logic         mHalted;
    logic         expWe, expHalt;
    logic [4:0]   expRd;
    logic [63:0]  expData, expNext;
    logic [31:0]  curInst;

    coreTop i_dut (
        .clk(clk), .rstN(rstN), .inst(inst), .pc(pc),
        .rdWe(rdWe), .rdAddr(rdAddr), .rdData(rdData), .halt(halt)
    );

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState ^ (lcgState >> 15);
    endfunction

    function automatic int wordIndex(input logic [63:0] addr);
        return int'((addr >> 2) % `IMEM_WORDS);
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic emitRandomArith();
        logic [31:0]  rv;
        logic [4:0]   rd, rs1, rs2;
        logic [11:0]  imm;
        int           sel;
        rv  = nextRand();
        rd  = 5'(1 + (rv % 15));
        rs1 = 5'(rv[11:8]);
        rs2 = 5'(rv[15:12]);
        imm = rv[27:16];
        sel = int'(nextRand() % 27);
        if (sel < 8) begin
            emit(encR(7'h00, rs2, rs1, 3'(sel), rd, 7'h33));
        end else if (sel < 10) begin
            emit(encR((sel == 8) ? 7'h20 : 7'h01, rs2, rs1, 3'd0, rd, 7'h33));  // sub, mul
        end else if (sel < 18) begin
            if (sel == 11 || sel == 15) imm = {6'h00, imm[5:0]};  // shamt only
            emit(encI(imm, rs1, 3'(sel - 10), rd, 7'h13));
        end else begin
            case (sel)
                18: emit(encR(7'h00, rs2, rs1, 3'd0, rd, 7'h3b));
                19: emit(encR(7'h20, rs2, rs1, 3'd0, rd, 7'h3b));
                20: emit(encR(7'h01, rs2, rs1, 3'd0, rd, 7'h3b));
                21: emit(encR(7'h01, rs2, rs1, 3'd5, rd, 7'h3b));
                22: emit(encR(7'h01, rs2, rs1, 3'd6, rd, 7'h3b));
                23: emit(encR(7'h01, rs2, rs1, 3'd7, rd, 7'h3b));
                24: emit(encI(imm, rs1, 3'd0, rd, 7'h1b));  // addiw
                25: emit({rv[31:12], rd, 7'h37});
                default: emit({rv[31:12], rd, 7'h17});
            endcase
        end
    endtask

    task automatic buildProgram();
        logic [31:0] rv;
        for (int i = 0; i < `IMEM_WORDS; i++) prog[i] = EBREAK;
        progLen = 0;
        for (int r = 1; r < 16; r++) begin
            rv = nextRand();
            emit({rv[31:12], 5'(r), 7'h37});
            emit(encI(rv[11:0], 5'(r), 3'd0, 5'(r), 7'h13));
        end
        repeat (60) emitRandomArith();
        emit(encR(7'h01, 5'd0, 5'd5, 3'd6, 5'd16, 7'h3b));  // remw by zero
        emit(encR(7'h01, 5'd0, 5'd6, 3'd5, 5'd17, 7'h3b));  // divuw by zero
        emit(encR(7'h01, 5'd0, 5'd7, 3'd7, 5'd18, 7'h3b));  // remuw by zero
        emit({20'h80000, 5'd19, 7'h37});
        emit(encI(12'hfff, 5'd0, 3'd0, 5'd20, 7'h13));
        emit(encR(7'h01, 5'd20, 5'd19, 3'd6, 5'd21, 7'h3b));  // remw overflow
        emit(encI(12'd64, 5'd0, 3'd0, 5'd22, 7'h13));
        emit(encS(12'd0, 5'd1, 5'd22, 3'd3));
        emit(encS(12'd8, 5'd2, 5'd22, 3'd2));
        emit(encS(12'd12, 5'd3, 5'd22, 3'd1));
        emit(encS(12'd14, 5'd4, 5'd22, 3'd0));
        emit(encS(12'd15, 5'd5, 5'd22, 3'd0));
        emit(encS(12'hff8, 5'd6, 5'd0, 3'd3));  // wraps to top of memory
        emit(encI(12'd0, 5'd22, 3'd3, 5'd23, 7'h03));
        emit(encI(12'd8, 5'd22, 3'd3, 5'd24, 7'h03));
        emit(encI(12'd4, 5'd22, 3'd2, 5'd25, 7'h03));
        emit(encI(12'd12, 5'd22, 3'd2, 5'd26, 7'h03));
        emit(encI(12'd2, 5'd22, 3'd1, 5'd27, 7'h03));
        emit(encI(12'd14, 5'd22, 3'd1, 5'd28, 7'h03));
        emit(encI(12'd6, 5'd22, 3'd5, 5'd29, 7'h03));
        emit(encI(12'd10, 5'd22, 3'd5, 5'd30, 7'h03));
        emit(encI(12'd7, 5'd22, 3'd0, 5'd31, 7'h03));
        emit(encI(12'd15, 5'd22, 3'd0, 5'd23, 7'h03));
        emit(encI(12'd3, 5'd22, 3'd4, 5'd24, 7'h03));
        emit(encI(12'd13, 5'd22, 3'd4, 5'd25, 7'h03));
        emit(encI(12'hff8, 5'd0, 3'd3, 5'd26, 7'h03));
        // each branch skips its filler when taken
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                emit(encB(13'd8, 5'd0, 5'd20, 3'(f)));
                emit(FILLER);
                emit(encB(13'd8, 5'd20, 5'd0, 3'(f)));
                emit(FILLER);
                emit(encB(13'd8, 5'd22, 5'd22, 3'(f)));
                emit(FILLER);
            end
        end
        emit(encI(12'd3, 5'd0, 3'd0, 5'd10, 7'h13));
        emit(encI(12'hfff, 5'd10, 3'd0, 5'd10, 7'h13));
        emit(encB(13'h1ffc, 5'd0, 5'd10, 3'd1));  // backward loop
        emit(encJ(21'd12, 5'd1));
        emit(FILLER);
        emit(FILLER);
        emit({20'h00000, 5'd5, 7'h17});
        emit(encI(12'd13, 5'd5, 3'd0, 5'd6, 7'h67));  // odd target loses bit 0
        emit(FILLER);
        emit(EBREAK);
    endtask

    function automatic logic [63:0] rdReg(input logic [4:0] r);
        return (r == 5'd0) ? 64'h0 : mReg[r];
    endfunction

    function automatic logic [63:0] intOp(input logic [2:0] f3, input logic sub,
                                          input logic [63:0] a, b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'h0, $signed(a) < $signed(b)};
            3'd3: return {63'h0, a < b};
            3'd4: return a ^ b;
            3'd5: return a >> b[5:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] wordOp(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [31:0] a, b);
        if (f7 == 7'h00) return a + b;
        if (f7 == 7'h20) return a - b;
        case (f3)
            3'd0: return a * b;
            3'd5: return (b == 0) ? 32'hffff_ffff : a / b;
            3'd6: begin
                if (b == 0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h0;
                return $signed(a) % $signed(b);
            end
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic logic [63:0] loadRef(input logic [63:0] addr, input logic [2:0] f3);
        logic [63:0] v;
        v = 64'h0;
        for (int i = 0; i < (1 << f3[1:0]); i++) begin
            v[8*i +: 8] = mMem[int'((addr + 64'(i)) % `DMEM_BYTES)];
        end
        if (!f3[2]) begin
            case (f3[1:0])
                2'd0: v = {{56{v[7]}}, v[7:0]};
                2'd1: v = {{48{v[15]}}, v[15:0]};
                2'd2: v = {{32{v[31]}}, v[31:0]};
                default: ;
            endcase
        end
        return v;
    endfunction

    // expectations for one instruction and its store
    task automatic predict(input logic [31:0] ins);
        logic [63:0]  a, b, immI, immS, immB, immJ, immU, addr;
        logic         taken;
        a = rdReg(ins[19:15]);
        b = rdReg(ins[24:20]);
        immI = {{52{ins[31]}}, ins[31:20]};
        immS = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {{32{ins[31]}}, ins[31:12], 12'h000};
        immJ = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        expWe   = 1'b0;
        expRd   = ins[11:7];
        expData = 64'h0;
        expNext = mPc + 64'd4;
        expHalt = 1'b0;
        if (mHalted || ins == EBREAK) begin
            expHalt = 1'b1;
            expNext = mPc;
        end else begin
            case (ins[6:0])
                7'h33: begin
                    expWe   = 1'b1;
                    expData = (ins[31:25] == 7'h01) ? a * b : intOp(ins[14:12], ins[30], a, b);
                end
                7'h13: begin
                    expWe   = 1'b1;
                    expData = intOp(ins[14:12], 1'b0, a, immI);
                end
                7'h3b, 7'h1b: begin
                    expWe   = 1'b1;
                    expData = (ins[6:0] == 7'h1b) ? 64'(a[31:0] + immI[31:0]) :
                              64'(wordOp(ins[31:25], ins[14:12], a[31:0], b[31:0]));
                    expData = {{32{expData[31]}}, expData[31:0]};
                end
                7'h37: {expWe, expData} = {1'b1, immU};
                7'h17: {expWe, expData} = {1'b1, mPc + immU};
                7'h03: {expWe, expData} = {1'b1, loadRef(a + immI, ins[14:12])};
                7'h23: begin
                    addr = a + immS;
                    for (int i = 0; i < (1 << ins[13:12]); i++) begin
                        mMem[int'((addr + 64'(i)) % `DMEM_BYTES)] = b[8*i +: 8];
                    end
                end
                7'h63: begin
                    case (ins[14:12])
                        3'd0: taken = (a == b);
                        3'd1: taken = (a != b);
                        3'd4: taken = ($signed(a) < $signed(b));
                        3'd5: taken = ($signed(a) >= $signed(b));
                        3'd6: taken = (a < b);
                        default: taken = (a >= b);
                    endcase
                    if (taken) expNext = mPc + immB;
                end
                7'h6f: {expWe, expData, expNext} = {1'b1, mPc + 64'd4, mPc + immJ};
                7'h67: {expWe, expData, expNext} = {1'b1, mPc + 64'd4, (a + immI) & ~64'd1};
                default: ;
            endcase
        end
    endtask

    task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    initial begin
        forever #50 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        #1 rstN = 1'b1;
    end

    initial begin
        buildProgram();
        inst = prog[0];
        forever begin
            @(posedge clk);
            #1 inst = prog[wordIndex(pc)];  // fetch follows the new pc
        end
    end

    initial begin
        for (int r = 0; r < 32; r++) mReg[r] = 64'h0;
        mPc     = `RESET_PC;
        mHalted = 1'b0;
        while (haltCycles < 8) begin
            @(negedge clk);
            if (!rstN) begin
                checkVal("pc", pc, `RESET_PC);
                checkVal("halt", 64'(halt), 64'h0);
                checkVal("rdWe", 64'(rdWe), 64'h0);
            end else begin
                curInst = prog[wordIndex(mPc)];
                predict(curInst);
                checkVal("pc", pc, mPc);
                checkVal("halt", 64'(halt), 64'(expHalt));
                checkVal("rdWe", 64'(rdWe), 64'(expWe));
                if (expWe) begin
                    checkVal("rdAddr", 64'(rdAddr), 64'(expRd));
                    checkVal("rdData", rdData, expData);
                end
                if (expWe && expRd != 5'd0) mReg[expRd] = expData;
                mPc     = expNext;
                mHalted = expHalt;
                if (mHalted) haltCycles++;
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (`IMEM_WORDS * 4 + 100) @(posedge clk);
        $display("timeout: the core never reached a halt, %0d errors so far", errors);
        $display("sim failed");
        $finish;
    end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module alu import rvPkg::*; (
    input  aluOp_e            op,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    output logic [`XLEN-1:0]  result
);

    logic [5:0]   shamt;
    logic [31:0]  aLo;
    logic [31:0]  bLo;
    logic [31:0]  rem32;
    logic [31:0]  divu32;
    logic [31:0]  remu32;

    assign shamt = b[5:0];
    assign aLo   = a[31:0];
    assign bLo   = b[31:0];

    // word divide, RISC-V rules for zero divisor and overflow
    always_comb begin
        rem32  = aLo;
        divu32 = '1;
        remu32 = aLo;
        if (bLo != 32'h0) begin
            divu32 = aLo / bLo;
            remu32 = aLo % bLo;
            if (aLo == 32'h8000_0000 && bLo == 32'hffff_ffff) begin
                rem32 = 32'h0;
            end else begin
                rem32 = $signed(aLo) % $signed(bLo);
            end
        end
    end

    always_comb begin
        case (op)
            ALU_ADD:      result = a + b;
            ALU_SUB:      result = a - b;
            ALU_MUL:      result = a * b;  // low half only
            ALU_XOR:      result = a ^ b;
            ALU_OR:       result = a | b;
            ALU_AND:      result = a & b;
            ALU_SLL:      result = a << shamt;
            ALU_SRL:      result = a >> shamt;
            ALU_SLT:      result = `XLEN'($signed(a) < $signed(b));
            ALU_SLTU:     result = `XLEN'(a < b);
            ALU_REM:      result = `XLEN'(rem32);
            ALU_DIVU:     result = `XLEN'(divu32);
            ALU_REMU:     result = `XLEN'(remu32);
            ALU_RETURN_B: result = b;
            default:      result = '0;
        endcase
    end

endmodule

/* src/coreTop.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module coreTop import rvPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic [31:0]       inst,
    output logic [`XLEN-1:0]  pc,
    output logic              rdWe,
    output logic [4:0]        rdAddr,
    output logic [`XLEN-1:0]  rdData,
    output logic              halt
);

    logic [`XLEN-1:0]  imm, rs1Data, rs2Data, opA, opB, aluResult, loadData, pcPlus4, nextPc;
    aluOp_e            aluOp;
    wbSel_e            wbSel;
    logic              selA, selB, writeRd, pcSel, npcOp, memRead, loadSext, isEbreak;
    logic              haltQ, commitEn;
    logic [3:0]        loadBytes;
    logic [7:0]        storeMask;

    immGen i_immGen (.inst(inst), .imm(imm));

    decoder i_decoder (
        .inst(inst), .imm(imm), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .aluOp(aluOp), .selA(selA), .selB(selB), .writeRd(writeRd), .pcSel(pcSel),
        .npcOp(npcOp), .wbSel(wbSel), .memRead(memRead), .loadSext(loadSext),
        .loadBytes(loadBytes), .storeMask(storeMask), .isEbreak(isEbreak)
    );

    regFile i_regFile (
        .clk(clk), .rstN(rstN), .we(rdWe), .waddr(rdAddr), .wdata(rdData),
        .raddr1(inst[19:15]), .raddr2(inst[24:20]), .rdata1(rs1Data), .rdata2(rs2Data)
    );

    assign opA = selA ? rs1Data : pc;
    assign opB = selB ? rs2Data : imm;

    alu i_alu (.op(aluOp), .a(opA), .b(opB), .result(aluResult));

    dataMem i_dataMem (
        .clk(clk), .addr(aluResult), .storeData(rs2Data),
        .storeMask(commitEn ? storeMask : 8'h00),
        .loadBytes(memRead ? loadBytes : 4'h0), .loadSext(loadSext), .loadData(loadData)
    );

    assign halt     = haltQ | isEbreak;  // ebreak stops this cycle already
    assign commitEn = rstN & ~halt;
    assign pcPlus4  = pc + `XLEN'd4;
    assign rdWe     = commitEn & writeRd;
    assign rdAddr   = inst[11:7];

    always_comb begin
        case (wbSel)
            WB_MEM:      rdData = loadData;
            WB_PC_PLUS4: rdData = pcPlus4;  // link value
            WB_ALU_W32:  rdData = `XLEN'($signed(aluResult[31:0]));
            default:     rdData = aluResult;
        endcase
    end

    assign nextPc = !npcOp ? pcPlus4 :
                    pcSel  ? ((rs1Data + imm) & ~`XLEN'd1) : (pc + imm);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc    <= `RESET_PC;
            haltQ <= 1'b0;
        end else begin
            if (!halt) pc <= nextPc;
            if (isEbreak) haltQ <= 1'b1;  // sticky until reset
        end
    end

endmodule

/* src/dataMem.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module dataMem (
    input  logic              clk,
    input  logic [`XLEN-1:0]  addr,
    input  logic [`XLEN-1:0]  storeData,
    input  logic [7:0]        storeMask,
    input  logic [3:0]        loadBytes,
    input  logic              loadSext,
    output logic [`XLEN-1:0]  loadData
);

    localparam int AW = $clog2(`DMEM_BYTES);

    logic [7:0]     mem [`DMEM_BYTES];
    logic [AW-1:0]  base;
    logic [63:0]    raw;

    assign base = addr[AW-1:0];  // wraps modulo memory size

    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (storeMask[i]) begin
                mem[base + AW'(i)] <= storeData[8*i +: 8];
            end
        end
    end

    // little endian gather of eight bytes from base
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            raw[8*i +: 8] = mem[base + AW'(i)];
        end
    end

    always_comb begin
        case (loadBytes)
            4'h1: begin
                loadData = loadSext ? `XLEN'($signed(raw[7:0])) : `XLEN'(raw[7:0]);
            end
            4'h2: begin
                loadData = loadSext ? `XLEN'($signed(raw[15:0])) : `XLEN'(raw[15:0]);
            end
            4'h4: begin
                loadData = loadSext ? `XLEN'($signed(raw[31:0])) : `XLEN'(raw[31:0]);
            end
            4'h8: loadData = `XLEN'(raw);
            default: loadData = '0;  // no load this cycle
        endcase
    end

endmodule

/* src/decoder.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module decoder import rvPkg::*; (
    input  logic [31:0]       inst,
    input  logic [`XLEN-1:0]  imm,
    input  logic [`XLEN-1:0]  rs1Data,
    input  logic [`XLEN-1:0]  rs2Data,
    output aluOp_e            aluOp,
    output logic              selA,
    output logic              selB,
    output logic              writeRd,
    output logic              pcSel,
    output logic              npcOp,
    output wbSel_e            wbSel,
    output logic              memRead,
    output logic              loadSext,
    output logic [3:0]        loadBytes,
    output logic [7:0]        storeMask,
    output logic              isEbreak
);

    opcode_e     opcode;
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic        rsEq;
    logic        rsLt;
    logic        rsLtu;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];

    assign rsEq  = (rs1Data == rs2Data);
    assign rsLt  = ($signed(rs1Data) < $signed(rs2Data));
    assign rsLtu = (rs1Data < rs2Data);

    assign isEbreak = (opcode == OPC_SYSTEM) && (funct3 == 3'b000) && (imm == `XLEN'd1);

    always_comb begin
        aluOp     = ALU_NONE;
        selA      = 1'b1;      // rs1
        selB      = 1'b0;      // imm
        writeRd   = 1'b0;
        pcSel     = 1'b0;
        npcOp     = 1'b0;
        wbSel     = WB_ALU;
        memRead   = 1'b0;
        loadSext  = 1'b0;
        loadBytes = 4'h0;
        storeMask = 8'h00;
        case (opcode)
            OPC_OP: begin
                selB = 1'b1;
                if (funct7 == 7'h00) begin
                    case (funct3)
                        3'b000: aluOp = ALU_ADD;
                        3'b001: aluOp = ALU_SLL;
                        3'b010: aluOp = ALU_SLT;
                        3'b011: aluOp = ALU_SLTU;
                        3'b100: aluOp = ALU_XOR;
                        3'b101: aluOp = ALU_SRL;
                        3'b110: aluOp = ALU_OR;
                        default: aluOp = ALU_AND;
                    endcase
                end else if (funct7 == 7'h20 && funct3 == 3'b000) begin
                    aluOp = ALU_SUB;
                end else if (funct7 == 7'h01 && funct3 == 3'b000) begin
                    aluOp = ALU_MUL;
                end
                writeRd = (aluOp != ALU_NONE);
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: aluOp = ALU_ADD;
                    3'b001: aluOp = (inst[31:26] == 6'h0) ? ALU_SLL : ALU_NONE;
                    3'b010: aluOp = ALU_SLT;
                    3'b011: aluOp = ALU_SLTU;
                    3'b100: aluOp = ALU_XOR;
                    3'b101: aluOp = (inst[31:26] == 6'h0) ? ALU_SRL : ALU_NONE;  // no srai
                    3'b110: aluOp = ALU_OR;
                    default: aluOp = ALU_AND;
                endcase
                writeRd = (aluOp != ALU_NONE);
            end
            OPC_AUIPC: begin
                selA    = 1'b0;    // pc + imm
                aluOp   = ALU_ADD;
                writeRd = 1'b1;
            end
            OPC_LUI: begin
                selA    = 1'b0;
                aluOp   = ALU_RETURN_B;
                writeRd = 1'b1;
            end
            OPC_LOAD: begin
                wbSel = WB_MEM;
                aluOp = ALU_ADD;   // address rs1 + imm
                case (funct3)
                    3'h0: {loadSext, loadBytes} = {1'b1, 4'h1};
                    3'h1: {loadSext, loadBytes} = {1'b1, 4'h2};
                    3'h2: {loadSext, loadBytes} = {1'b1, 4'h4};
                    3'h3: {loadSext, loadBytes} = {1'b1, 4'h8};
                    3'h4: {loadSext, loadBytes} = {1'b0, 4'h1};
                    3'h5: {loadSext, loadBytes} = {1'b0, 4'h2};
                    default: aluOp = ALU_NONE;
                endcase
                memRead = (aluOp != ALU_NONE);
                writeRd = (aluOp != ALU_NONE);
            end
            OPC_STORE: begin
                aluOp = ALU_ADD;
                case (funct3)
                    3'b000: storeMask = 8'b0000_0001;
                    3'b001: storeMask = 8'b0000_0011;
                    3'b010: storeMask = 8'b0000_1111;
                    3'b011: storeMask = 8'b1111_1111;
                    default: aluOp = ALU_NONE;
                endcase
            end
            OPC_OP_32: begin
                selB  = 1'b1;
                wbSel = WB_ALU_W32;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: aluOp = ALU_ADD;   // addw
                    {7'h20, 3'b000}: aluOp = ALU_SUB;   // subw
                    {7'h01, 3'b000}: aluOp = ALU_MUL;   // mulw
                    {7'h01, 3'b101}: aluOp = ALU_DIVU;  // divuw
                    {7'h01, 3'b110}: aluOp = ALU_REM;   // remw
                    {7'h01, 3'b111}: aluOp = ALU_REMU;  // remuw
                    default: aluOp = ALU_NONE;
                endcase
                writeRd = (aluOp != ALU_NONE);
            end
            OPC_OP_IMM_32: begin
                wbSel = WB_ALU_W32;
                if (funct3 == 3'b000) begin
                    aluOp   = ALU_ADD;  // addiw
                    writeRd = 1'b1;
                end
            end
            OPC_JAL: begin
                writeRd = 1'b1;
                npcOp   = 1'b1;        // pc + imm
                wbSel   = WB_PC_PLUS4;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    writeRd = 1'b1;
                    pcSel   = 1'b1;    // rs1 + imm
                    npcOp   = 1'b1;
                    wbSel   = WB_PC_PLUS4;
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'h0: npcOp = rsEq;
                    3'h1: npcOp = !rsEq;
                    3'h4: npcOp = rsLt;
                    3'h5: npcOp = !rsLt;   // bge
                    3'h6: npcOp = rsLtu;
                    3'h7: npcOp = !rsLtu;  // bgeu
                    default: npcOp = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* src/immGen.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module immGen import rvPkg::*; (
    input  logic [31:0]       inst,
    output logic [`XLEN-1:0]  imm
);

    opcode_e      opcode;
    logic [11:0]  immI;
    logic [11:0]  immS;
    logic [12:0]  immB;
    logic [31:0]  immU;
    logic [20:0]  immJ;

    assign opcode = opcode_e'(inst[6:0]);

    assign immI = inst[31:20];
    assign immS = {inst[31:25], inst[11:7]};
    assign immB = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'h000};
    assign immJ = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_LOAD,
            OPC_JALR, OPC_SYSTEM:   imm = `XLEN'($signed(immI));  // ebreak gives 1
            OPC_STORE:              imm = `XLEN'($signed(immS));
            OPC_BRANCH:             imm = `XLEN'($signed(immB));
            OPC_LUI, OPC_AUIPC:     imm = `XLEN'($signed(immU));
            OPC_JAL:                imm = `XLEN'($signed(immJ));
            default:                imm = '0;  // R forms carry none
        endcase
    end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  logic              we,
    input  logic [4:0]        waddr,
    input  logic [`XLEN-1:0]  wdata,
    input  logic [4:0]        raddr1,
    input  logic [4:0]        raddr2,
    output logic [`XLEN-1:0]  rdata1,
    output logic [`XLEN-1:0]  rdata2
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

/* src/rvPkg.sv */
package rvPkg;

    typedef enum logic [3:0] {
        ALU_ADD      = 4'd0,
        ALU_SUB      = 4'd1,
        ALU_MUL      = 4'd2,
        ALU_XOR      = 4'd3,
        ALU_OR       = 4'd4,
        ALU_AND      = 4'd5,
        ALU_SLL      = 4'd6,
        ALU_SRL      = 4'd7,
        ALU_SLT      = 4'd8,
        ALU_SLTU     = 4'd9,
        ALU_REM      = 4'd10,  // signed, low word
        ALU_DIVU     = 4'd11,  // unsigned, low word
        ALU_REMU     = 4'd12,  // unsigned, low word
        ALU_RETURN_B = 4'd13,  // pass b through, lui
        ALU_NONE     = 4'd15
    } aluOp_e;

    typedef enum logic [2:0] {
        WB_ALU      = 3'b000,
        WB_MEM      = 3'b001,
        WB_PC_PLUS4 = 3'b010,
        WB_ALU_W32  = 3'b100   // low word, sign extended
    } wbSel_e;

    typedef enum logic [6:0] {
        OPC_LOAD       = 7'b0000011,
        OPC_OP_IMM     = 7'b0010011,
        OPC_AUIPC      = 7'b0010111,
        OPC_OP_IMM_32  = 7'b0011011,
        OPC_STORE      = 7'b0100011,
        OPC_OP         = 7'b0110011,
        OPC_LUI        = 7'b0110111,
        OPC_OP_32      = 7'b0111011,
        OPC_BRANCH     = 7'b1100011,
        OPC_JALR       = 7'b1100111,
        OPC_JAL        = 7'b1101111,
        OPC_SYSTEM     = 7'b1110011
    } opcode_e;

endpackage

/* src/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// register and datapath width
`define XLEN 64

// instruction words served on the fetch port
`define IMEM_WORDS 256

// internal data memory, addressed modulo its size
`define DMEM_BYTES 512

// first fetch address out of reset
`define RESET_PC 64'h0000_0000_0000_0000

`endif
